// File: xbar_pkg.sv
// Fixed 32-bit address and data, targets addressed by a 4-bit index so at most 16 targets
`default_nettype none

package xbar_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Response code, only two values are produced by this crossbar
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  // Target index, modules use only as many low bits as they need
  typedef logic [3:0] tgt_idx_t;

  // Request side of one transfer, held stable while req is high
  typedef struct packed {
    logic  write;  // 1 = write, 0 = read
    addr_t addr;
    data_t wdata;
  } req_payload_t;

  // Response side, valid while ack is high
  typedef struct packed {
    data_t rdata;  // Zero on writes and errors
    resp_t resp;
  } rsp_payload_t;

  // Address rule, half-open range [start_addr, end_addr)
  typedef struct packed {
    tgt_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } xbar_rule_t;

endpackage

`default_nettype wire

// File: xbar_addr_decode.sv
// Purely combinational; overlapping rules resolve to the highest-numbered match
`default_nettype none
`timescale 1ns/1ps

module xbar_addr_decode #(
  parameter int unsigned NumTgt   = 2,
  parameter int unsigned NumRules = 2
) (
  input  xbar_pkg::addr_t                      addr_i,
  input  xbar_pkg::xbar_rule_t [NumRules-1:0]  addr_map_i,
  input  logic                                 en_default_i,
  input  xbar_pkg::tgt_idx_t                   default_idx_i,
  output xbar_pkg::tgt_idx_t                   idx_o,
  output logic                                 dec_error_o
);

  import xbar_pkg::*;

  logic     match;
  tgt_idx_t match_idx;

  // Later rules overwrite earlier ones
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int unsigned r = 0; r < NumRules; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        match     = 1'b1;
        match_idx = addr_map_i[r].idx;
      end
    end
  end

  always_comb begin
    if (match) begin
      idx_o       = match_idx;
      dec_error_o = (match_idx >= NumTgt);  // Rule points past the last target
    end else if (en_default_i) begin
      idx_o       = default_idx_i;
      dec_error_o = (default_idx_i >= NumTgt);
    end else begin
      idx_o       = '0;
      dec_error_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: xbar_demux.sv
// One transfer in flight; the route and the payload are latched at the start of each transfer
`default_nettype none
`timescale 1ns/1ps

module xbar_demux #(
  parameter int unsigned NumTgt   = 2,
  parameter int unsigned NumRules = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 req_i,
  input  xbar_pkg::req_payload_t               payload_i,
  output logic                                 ack_o,
  output xbar_pkg::rsp_payload_t               rsp_o,
  input  xbar_pkg::xbar_rule_t [NumRules-1:0]  addr_map_i,
  input  logic                                 en_default_i,
  input  xbar_pkg::tgt_idx_t                   default_idx_i,
  output logic [NumTgt:0]                      lane_req_o,
  output xbar_pkg::req_payload_t               lane_payload_o,
  input  logic [NumTgt:0]                      lane_ack_i,
  input  xbar_pkg::rsp_payload_t [NumTgt:0]    lane_rsp_i
);

  import xbar_pkg::*;

  localparam int unsigned SelW = $clog2(NumTgt + 1);

  typedef logic [SelW-1:0] lane_sel_t;  // Lane NumTgt is the error responder

  typedef enum logic [1:0] {
    IDLE,
    FWD,
    DRAIN
  } state_e;

  state_e       state_q;
  lane_sel_t    sel_q;
  logic         lane_req_q;
  logic         ack_q;
  req_payload_t payload_q;
  rsp_payload_t rsp_q;
  tgt_idx_t     dec_idx;
  logic         dec_error;

  xbar_addr_decode #(
    .NumTgt   ( NumTgt   ),
    .NumRules ( NumRules )
  ) u_addr_decode (
    .addr_i        ( payload_i.addr ),
    .addr_map_i    ( addr_map_i     ),
    .en_default_i  ( en_default_i   ),
    .default_idx_i ( default_idx_i  ),
    .idx_o         ( dec_idx        ),
    .dec_error_o   ( dec_error      )
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      sel_q      <= '0;
      lane_req_q <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (req_i) begin
          sel_q      <= dec_error ? lane_sel_t'(NumTgt) : lane_sel_t'(dec_idx);
          lane_req_q <= 1'b1;
          state_q    <= FWD;
        end
        FWD: begin
          if (!ack_q) begin
            ack_q <= lane_ack_i[sel_q];  // Response captured below on the same edge
          end else if (!req_i) begin
            lane_req_q <= 1'b0;
            state_q    <= DRAIN;
          end
        end
        DRAIN: if (!lane_ack_i[sel_q]) begin
          ack_q   <= 1'b0;
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload and response registers
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) payload_q <= payload_i;
    if (state_q == FWD && !ack_q && lane_ack_i[sel_q]) rsp_q <= lane_rsp_i[sel_q];
  end

  always_comb begin
    for (int unsigned k = 0; k <= NumTgt; k++) begin
      lane_req_o[k] = lane_req_q && (sel_q == lane_sel_t'(k));
    end
  end

  assign lane_payload_o = payload_q;
  assign ack_o          = ack_q;
  assign rsp_o          = rsp_q;

endmodule

`default_nettype wire

// File: xbar_err_target.sv
// Answers every transfer with a decode error and zero read data, never stalls
`default_nettype none
`timescale 1ns/1ps

module xbar_err_target (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  output logic                   ack_o,
  output xbar_pkg::rsp_payload_t rsp_o
);

  import xbar_pkg::*;

  logic ack_q;

  // Ack mirrors req one cycle late, which completes all four phases
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  assign ack_o = ack_q;

  // Constant response
  always_comb begin
    rsp_o       = '0;
    rsp_o.rdata = '0;
    rsp_o.resp  = RESP_DECERR;
  end

endmodule

`default_nettype wire

// File: xbar_mux.sv
// Round-robin over initiator lanes; a grant is held until req and ack are both low again
`default_nettype none
`timescale 1ns/1ps

module xbar_mux #(
  parameter int unsigned NumInit = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [NumInit-1:0]                    lane_req_i,
  input  xbar_pkg::req_payload_t [NumInit-1:0]  lane_payload_i,
  output logic [NumInit-1:0]                    lane_ack_o,
  output xbar_pkg::rsp_payload_t [NumInit-1:0]  lane_rsp_o,
  output logic                                  tgt_req_o,
  output xbar_pkg::req_payload_t                tgt_payload_o,
  input  logic                                  tgt_ack_i,
  input  xbar_pkg::rsp_payload_t                tgt_rsp_i
);

  localparam int unsigned IdxW = (NumInit > 1) ? $clog2(NumInit) : 1;

  typedef logic [IdxW-1:0] init_idx_t;

  logic      gnt_valid_q;
  init_idx_t gnt_idx_q;    // Also the round-robin pointer once released
  logic      next_found;
  init_idx_t next_idx;

  // Search starts one past the last granted lane
  always_comb begin
    int unsigned cand;
    next_found = 1'b0;
    next_idx   = gnt_idx_q;
    for (int unsigned n = 1; n <= NumInit; n++) begin
      cand = (int'(gnt_idx_q) + n) % NumInit;
      if (!next_found && lane_req_i[cand]) begin
        next_found = 1'b1;
        next_idx   = init_idx_t'(cand);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= init_idx_t'(NumInit - 1);  // Lane 0 goes first
    end else if (!gnt_valid_q) begin
      if (next_found) begin
        gnt_valid_q <= 1'b1;
        gnt_idx_q   <= next_idx;
      end
    end else if (!tgt_req_o && !tgt_ack_i) begin
      gnt_valid_q <= 1'b0;  // Four phases done
    end
  end

  assign tgt_req_o     = gnt_valid_q && lane_req_i[gnt_idx_q];
  assign tgt_payload_o = lane_payload_i[gnt_idx_q];

  // Ack and response go back to the granted lane only
  always_comb begin
    for (int unsigned k = 0; k < NumInit; k++) begin
      if (gnt_valid_q && (gnt_idx_q == init_idx_t'(k))) begin
        lane_ack_o[k] = tgt_ack_i;
        lane_rsp_o[k] = tgt_rsp_i;
      end else begin
        lane_ack_o[k] = 1'b0;
        lane_rsp_o[k] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: xbar_top.sv
// Each initiator may have one transfer outstanding; rules and defaults must stay stable during it
`default_nettype none
`timescale 1ns/1ps

module xbar_top #(
  parameter int unsigned NumInit  = 2,
  parameter int unsigned NumTgt   = 2,
  parameter int unsigned NumRules = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [NumInit-1:0]                    init_req_i,
  input  xbar_pkg::req_payload_t [NumInit-1:0]  init_payload_i,
  output logic [NumInit-1:0]                    init_ack_o,
  output xbar_pkg::rsp_payload_t [NumInit-1:0]  init_rsp_o,
  output logic [NumTgt-1:0]                     tgt_req_o,
  output xbar_pkg::req_payload_t [NumTgt-1:0]   tgt_payload_o,
  input  logic [NumTgt-1:0]                     tgt_ack_i,
  input  xbar_pkg::rsp_payload_t [NumTgt-1:0]   tgt_rsp_i,
  input  xbar_pkg::xbar_rule_t [NumRules-1:0]   addr_map_i,
  input  logic [NumInit-1:0]                    en_default_i,
  input  xbar_pkg::tgt_idx_t [NumInit-1:0]      default_idx_i
);

  import xbar_pkg::*;

  // Initiator-major lanes, one extra lane per initiator for the error responder
  logic         [NumInit-1:0][NumTgt:0] lane_req;
  logic         [NumInit-1:0][NumTgt:0] lane_ack;
  rsp_payload_t [NumInit-1:0][NumTgt:0] lane_rsp;
  req_payload_t [NumInit-1:0]           lane_payload;

  // Same lanes seen from the target side
  logic         [NumTgt-1:0][NumInit-1:0] x_req;
  logic         [NumTgt-1:0][NumInit-1:0] x_ack;
  req_payload_t [NumTgt-1:0][NumInit-1:0] x_payload;
  rsp_payload_t [NumTgt-1:0][NumInit-1:0] x_rsp;

  for (genvar i = 0; i < NumInit; i++) begin : gen_init
    xbar_demux #(
      .NumTgt   ( NumTgt   ),
      .NumRules ( NumRules )
    ) u_demux (
      .clk_i          ( clk_i             ),
      .rst_i          ( rst_i             ),
      .req_i          ( init_req_i[i]     ),
      .payload_i      ( init_payload_i[i] ),
      .ack_o          ( init_ack_o[i]     ),
      .rsp_o          ( init_rsp_o[i]     ),
      .addr_map_i     ( addr_map_i        ),
      .en_default_i   ( en_default_i[i]   ),
      .default_idx_i  ( default_idx_i[i]  ),
      .lane_req_o     ( lane_req[i]       ),
      .lane_payload_o ( lane_payload[i]   ),
      .lane_ack_i     ( lane_ack[i]       ),
      .lane_rsp_i     ( lane_rsp[i]       )
    );

    xbar_err_target u_err_target (
      .clk_i ( clk_i                ),
      .rst_i ( rst_i                ),
      .req_i ( lane_req[i][NumTgt]  ),
      .ack_o ( lane_ack[i][NumTgt]  ),
      .rsp_o ( lane_rsp[i][NumTgt]  )
    );

    for (genvar j = 0; j < NumTgt; j++) begin : gen_cross
      assign x_req[j][i]     = lane_req[i][j];
      assign x_payload[j][i] = lane_payload[i];
      assign lane_ack[i][j]  = x_ack[j][i];
      assign lane_rsp[i][j]  = x_rsp[j][i];
    end
  end

  for (genvar j = 0; j < NumTgt; j++) begin : gen_tgt
    xbar_mux #(
      .NumInit ( NumInit )
    ) u_mux (
      .clk_i          ( clk_i            ),
      .rst_i          ( rst_i            ),
      .lane_req_i     ( x_req[j]         ),
      .lane_payload_i ( x_payload[j]     ),
      .lane_ack_o     ( x_ack[j]         ),
      .lane_rsp_o     ( x_rsp[j]         ),
      .tgt_req_o      ( tgt_req_o[j]     ),
      .tgt_payload_o  ( tgt_payload_o[j] ),
      .tgt_ack_i      ( tgt_ack_i[j]     ),
      .tgt_rsp_i      ( tgt_rsp_i[j]     )
    );
  end

endmodule

`default_nettype wire

// File: xbar_assert.sv
// Four-phase rules on initiator, lane and target links are sampled on the rising clock outside reset
`default_nettype none
`timescale 1ns/1ps

module xbar_assert #(
  parameter int unsigned NumInit = 2,
  parameter int unsigned NumTgt  = 2
) (
  input logic                                 clk_i,
  input logic                                 rst_i,
  input logic [NumInit-1:0]                   init_req_i,
  input logic [NumInit-1:0]                   init_ack_i,
  input xbar_pkg::req_payload_t [NumInit-1:0] init_payload_i,
  input logic [NumInit-1:0][NumTgt:0]         lane_req_i,
  input logic [NumInit-1:0][NumTgt:0]         lane_ack_i,
  input logic [NumTgt-1:0]                    tgt_req_i,
  input logic [NumTgt-1:0]                    tgt_ack_i,
  input xbar_pkg::req_payload_t [NumTgt-1:0]  tgt_payload_i,
  input logic [NumTgt-1:0][NumInit-1:0]       mux_ack_i
);

  for (genvar i = 0; i < NumInit; i++) begin : gen_init
    assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(init_ack_i[i]) |-> init_req_i[i])
      else $error("init ack %0d rose without req", i);
    assert property (@(posedge clk_i) disable iff (rst_i)
      (init_req_i[i] && !init_ack_i[i]) |=> (!init_req_i[i] || $stable(init_payload_i[i])))
      else $error("init payload %0d changed before ack", i);
    for (genvar j = 0; j <= NumTgt; j++) begin : gen_lane
      assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(lane_ack_i[i][j]) |-> lane_req_i[i][j])
        else $error("lane ack %0d/%0d rose without req", i, j);
    end
  end

  for (genvar j = 0; j < NumTgt; j++) begin : gen_tgt
    assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(tgt_ack_i[j]) |-> tgt_req_i[j])
      else $error("target ack %0d rose without req", j);
    assert property (@(posedge clk_i) disable iff (rst_i)
      (tgt_req_i[j] && !tgt_ack_i[j]) |=> (!tgt_req_i[j] || $stable(tgt_payload_i[j])))
      else $error("target payload %0d changed before ack", j);
    // The grant must outlive the target ack so exactly one lane sees it
    assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_ack_i[j] |-> $onehot(mux_ack_i[j]))
      else $error("mux %0d passed the target ack to no lane or to several", j);
  end

endmodule

bind xbar_top xbar_assert #(
  .NumInit ( NumInit ),
  .NumTgt  ( NumTgt  )
) u_assert (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .init_req_i     ( init_req_i     ),
  .init_ack_i     ( init_ack_o     ),
  .init_payload_i ( init_payload_i ),
  .lane_req_i     ( lane_req       ),
  .lane_ack_i     ( lane_ack       ),
  .tgt_req_i      ( tgt_req_o      ),
  .tgt_ack_i      ( tgt_ack_i      ),
  .tgt_payload_i  ( tgt_payload_o  ),
  .mux_ack_i      ( x_ack          )
);

`default_nettype wire

// File: tb_xbar.sv
// Two initiators and two memory targets; each table row is one transfer, and a marked row runs with the next
`default_nettype none
`timescale 1ns/1ps

module tb_xbar;

  import xbar_pkg::*;

  localparam int unsigned NumInit  = 2;
  localparam int unsigned NumTgt   = 2;
  localparam int unsigned NumRules = 2;
  localparam int          NumRows  = 22;
  localparam int          Timeout  = 200;  // Cycles allowed per wait

  typedef struct packed {
    logic     pair;         // Runs at the same time as the next row
    logic     init;
    logic     write;
    addr_t    addr;
    data_t    wdata;
    logic     en_default;
    tgt_idx_t default_idx;
    resp_t    exp_resp;
    data_t    exp_rdata;
    tgt_idx_t exp_tgt;      // 4'hf when no target may see the request
  } stim_row_t;

  logic                          clk_i = 1'b0;
  logic                          rst_i;
  logic         [NumInit-1:0]    init_req_i;
  req_payload_t [NumInit-1:0]    init_payload_i;
  logic         [NumInit-1:0]    init_ack_o;
  rsp_payload_t [NumInit-1:0]    init_rsp_o;
  logic         [NumTgt-1:0]     tgt_req_o;
  req_payload_t [NumTgt-1:0]     tgt_payload_o;
  logic         [NumTgt-1:0]     tgt_ack_i = '0;
  rsp_payload_t [NumTgt-1:0]     tgt_rsp_i = '0;
  xbar_rule_t   [NumRules-1:0]   addr_map_i;
  logic         [NumInit-1:0]    en_default_i;
  tgt_idx_t     [NumInit-1:0]    default_idx_i;

  stim_row_t         rows [NumRows];
  data_t             mem [NumTgt][16];
  logic [NumTgt-1:0] armed = '0;
  logic [1:0]        wait_cnt [NumTgt];
  logic [31:0]       rng = 32'd68;
  logic [NumTgt-1:0] tgt_req_q = '0;
  int unsigned       hits [NumTgt] = '{default: 0};  // Rising edges of tgt_req_o
  int                err_cnt = 0;
  int                timeout_cnt = 0;

  always #4 clk_i = ~clk_i;

  xbar_top #(
    .NumInit  ( NumInit  ),
    .NumTgt   ( NumTgt   ),
    .NumRules ( NumRules )
  ) u_xbar_top (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .init_req_i     ( init_req_i     ),
    .init_payload_i ( init_payload_i ),
    .init_ack_o     ( init_ack_o     ),
    .init_rsp_o     ( init_rsp_o     ),
    .tgt_req_o      ( tgt_req_o      ),
    .tgt_payload_o  ( tgt_payload_o  ),
    .tgt_ack_i      ( tgt_ack_i      ),
    .tgt_rsp_i      ( tgt_rsp_i      ),
    .addr_map_i     ( addr_map_i     ),
    .en_default_i   ( en_default_i   ),
    .default_idx_i  ( default_idx_i  )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory targets that ack after 0 to 3 extra cycles
  always @(posedge clk_i) begin
    logic [3:0] word;
    for (int j = 0; j < NumTgt; j++) begin
      word = tgt_payload_o[j].addr[5:2];
      if (rst_i) begin
        tgt_ack_i[j] <= 1'b0;
        armed[j]     <= 1'b0;
      end else if (tgt_ack_i[j]) begin
        if (!tgt_req_o[j]) tgt_ack_i[j] <= 1'b0;
      end else if (tgt_req_o[j] && !armed[j]) begin
        rng = xorshift32(rng);
        armed[j]    <= 1'b1;
        wait_cnt[j] <= rng[1:0];
      end else if (armed[j] && wait_cnt[j] != 2'd0) begin
        wait_cnt[j] <= wait_cnt[j] - 2'd1;
      end else if (armed[j]) begin
        armed[j]           <= 1'b0;
        tgt_ack_i[j]       <= 1'b1;
        tgt_rsp_i[j].resp  <= RESP_OKAY;
        tgt_rsp_i[j].rdata <= tgt_payload_o[j].write ? '0 : mem[j][word];
        if (tgt_payload_o[j].write) mem[j][word] <= tgt_payload_o[j].wdata;
      end
    end
  end

  always @(posedge clk_i) begin
    tgt_req_q <= tgt_req_o;
    for (int j = 0; j < NumTgt; j++) begin
      if (tgt_req_o[j] && !tgt_req_q[j]) hits[j] <= hits[j] + 1;
    end
  end

  // pair, init, write, addr, wdata, en_default, default_idx, resp, rdata, target
  initial begin
    rows[0]  = '{1'b0, 1'b0, 1'b1, 32'h0004, 32'h1111_00a1, 1'b0, 4'd0, RESP_OKAY, 32'h0, 4'd0};
    rows[1]  = '{1'b0, 1'b0, 1'b0, 32'h0004, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h1111_00a1, 4'd0};
    rows[2]  = '{1'b0, 1'b1, 1'b1, 32'h1008, 32'h2222_00b2, 1'b0, 4'd0, RESP_OKAY, 32'h0, 4'd1};
    rows[3]  = '{1'b0, 1'b1, 1'b0, 32'h1008, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h2222_00b2, 4'd1};
    rows[4]  = '{1'b0, 1'b1, 1'b1, 32'h0010, 32'h3333_00c3, 1'b0, 4'd0, RESP_OKAY, 32'h0, 4'd0};
    rows[5]  = '{1'b0, 1'b0, 1'b0, 32'h0010, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h3333_00c3, 4'd0};
    rows[6]  = '{1'b0, 1'b0, 1'b1, 32'h1014, 32'h4444_00d4, 1'b0, 4'd0, RESP_OKAY, 32'h0, 4'd1};
    rows[7]  = '{1'b0, 1'b1, 1'b0, 32'h1014, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h4444_00d4, 4'd1};
    // Unmapped address with the default off
    rows[8]  = '{1'b0, 1'b0, 1'b1, 32'h3000, 32'hdead_beef, 1'b0, 4'd0, RESP_DECERR, 32'h0, 4'hf};
    rows[9]  = '{1'b0, 1'b1, 1'b0, 32'h3000, 32'h0, 1'b0, 4'd0, RESP_DECERR, 32'h0, 4'hf};
    // Default target 1 holds word 0 of both 0x3000 and 0x1000
    rows[10] = '{1'b0, 1'b0, 1'b1, 32'h3000, 32'h5555_00e5, 1'b1, 4'd1, RESP_OKAY, 32'h0, 4'd1};
    rows[11] = '{1'b0, 1'b0, 1'b0, 32'h3000, 32'h0, 1'b1, 4'd1, RESP_OKAY, 32'h5555_00e5, 4'd1};
    rows[12] = '{1'b0, 1'b1, 1'b0, 32'h1000, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h5555_00e5, 4'd1};
    // Pairs contend for one target
    rows[13] = '{1'b1, 1'b0, 1'b1, 32'h0020, 32'h6666_0011, 1'b0, 4'd0, RESP_OKAY, 32'h0, 4'd0};
    rows[14] = '{1'b0, 1'b1, 1'b1, 32'h0024, 32'h7777_0022, 1'b0, 4'd0, RESP_OKAY, 32'h0, 4'd0};
    rows[15] = '{1'b1, 1'b0, 1'b0, 32'h0024, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h7777_0022, 4'd0};
    rows[16] = '{1'b0, 1'b1, 1'b0, 32'h0020, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h6666_0011, 4'd0};
    rows[17] = '{1'b1, 1'b0, 1'b0, 32'h1014, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h4444_00d4, 4'd1};
    rows[18] = '{1'b0, 1'b1, 1'b0, 32'h1008, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h2222_00b2, 4'd1};
    rows[19] = '{1'b1, 1'b0, 1'b1, 32'h3004, 32'h8888_0055, 1'b1, 4'd1, RESP_OKAY, 32'h0, 4'd1};
    rows[20] = '{1'b0, 1'b1, 1'b0, 32'h3000, 32'h0, 1'b0, 4'd0, RESP_DECERR, 32'h0, 4'hf};
    rows[21] = '{1'b0, 1'b1, 1'b0, 32'h1004, 32'h0, 1'b0, 4'd0, RESP_OKAY, 32'h8888_0055, 4'd1};
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
    err_cnt++;
  endtask

  // One full four-phase transfer on the row's initiator
  task automatic run_transfer(input int r);
    stim_row_t row;
    int        i;
    int        t;
    row = rows[r];
    i   = int'(row.init);
    @(posedge clk_i);
    en_default_i[i]         <= row.en_default;
    default_idx_i[i]        <= row.default_idx;
    init_payload_i[i].write <= row.write;
    init_payload_i[i].addr  <= row.addr;
    init_payload_i[i].wdata <= row.wdata;
    init_req_i[i]           <= 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!init_ack_o[i] && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (!init_ack_o[i]) begin
      $display("Timeout: initiator %0d got no ack for row %0d", i, r);
      timeout_cnt++;
      return;
    end
    if (init_rsp_o[i].resp !== row.exp_resp) begin
      report_mismatch($sformatf("init_rsp_o[%0d].resp", i), 32'(row.exp_resp),
                      32'(init_rsp_o[i].resp));
    end
    if (init_rsp_o[i].rdata !== row.exp_rdata) begin
      report_mismatch($sformatf("init_rsp_o[%0d].rdata", i), row.exp_rdata,
                      init_rsp_o[i].rdata);
    end
    @(posedge clk_i);
    init_req_i[i] <= 1'b0;
    t = 0;
    @(negedge clk_i);
    while (init_ack_o[i] && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (init_ack_o[i]) begin
      $display("Timeout: ack of initiator %0d stayed high after row %0d", i, r);
      timeout_cnt++;
    end
  endtask

  initial begin
    int unsigned hits_before [NumTgt];
    int unsigned exp_delta [NumTgt];
    int          r;
    int          n;
    rst_i          = 1'b1;
    init_req_i     = '0;
    init_payload_i = '0;
    en_default_i   = '0;
    default_idx_i  = '0;
    addr_map_i[0]  = '{idx: 4'd0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
    addr_map_i[1]  = '{idx: 4'd1, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (2) @(negedge clk_i);
    if (init_ack_o !== '0) report_mismatch("init_ack_o", 32'h0, 32'(init_ack_o));
    if (tgt_req_o !== '0) report_mismatch("tgt_req_o", 32'h0, 32'(tgt_req_o));
    r = 0;
    while (r < NumRows && timeout_cnt == 0) begin
      n = rows[r].pair ? 2 : 1;
      for (int j = 0; j < NumTgt; j++) begin
        hits_before[j] = hits[j];
        exp_delta[j]   = 0;
      end
      for (int k = r; k < r + n; k++) begin
        if (rows[k].exp_tgt < NumTgt) exp_delta[rows[k].exp_tgt]++;
      end
      if (n == 2) begin
        fork
          run_transfer(r);
          run_transfer(r + 1);
        join
      end else begin
        run_transfer(r);
      end
      for (int j = 0; j < NumTgt; j++) begin
        if (hits[j] - hits_before[j] != exp_delta[j]) begin
          report_mismatch($sformatf("tgt_req_o[%0d] starts", j), exp_delta[j],
                          hits[j] - hits_before[j]);
        end
      end
      r += n;
    end
    $display("Errors: %0d wrong values, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
xbar_pkg.sv
xbar_addr_decode.sv
xbar_demux.sv
xbar_err_target.sv
xbar_mux.sv
xbar_top.sv
xbar_assert.sv
tb_xbar.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_xbar -f tb.f -o tb_xbar_sim > build.log 2>&1 &&
  ./obj_dir/tb_xbar_sim > sim.log 2>&1
grep -qs '\*\* PASS \*\*' sim.log && echo "simulation passed" || { echo "simulation failed, see build.log and sim.log"; exit 1; }
